//--- project.f
design/mipsCtrlPkg.sv
design/functDecoder.sv
design/opcodeDecoder.sv
design/commitStage.sv
design/controlUnit.sv
test/controlUnitTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module controlUnitTb &&
./obj_dir/VcontrolUnitTb | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- test/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	localparam int numIrq = 8;
	localparam int numRandom = 200;
	localparam int resetCycles = 5;
	localparam int period = 100;

	typedef struct packed {
		mipsCtrlPkg::instr_t w;
		logic                eq0;
		logic                excLvl;
		logic                ovf;
		logic                user;
		logic [numIrq-1:0]   irq;
	} stim_t;

	logic iCLK = 1'b0;
	logic rstN;
	mipsCtrlPkg::instr_t instr;
	logic equal0;
	logic excLevel;
	logic aluOverflow;
	logic userMode;
	logic [numIrq-1:0] pendingIrq;
	mipsCtrlPkg::ctrlWord_t ctrl;
	mipsCtrlPkg::excOut_t exc;

	mipsCtrlPkg::ctrlWord_t nextCtrl;
	mipsCtrlPkg::excOut_t nextExc;
	mipsCtrlPkg::ctrlWord_t expCtrl;
	mipsCtrlPkg::excOut_t expExc;
	logic checkOn = 1'b0;
	logic listReady = 1'b0;
	int errCount = 0;
	int checkCount = 0;
	int seed = 32'h4202_90e5;
	stim_t dirQ[$];

	logic [5:0] opList[$] = '{
		mipsCtrlPkg::opcRType, mipsCtrlPkg::opcCop0, mipsCtrlPkg::opcLw, mipsCtrlPkg::opcLh,
		mipsCtrlPkg::opcLb, mipsCtrlPkg::opcLhu, mipsCtrlPkg::opcLbu, mipsCtrlPkg::opcSw,
		mipsCtrlPkg::opcSh, mipsCtrlPkg::opcSb, mipsCtrlPkg::opcBeq, mipsCtrlPkg::opcBne,
		mipsCtrlPkg::opcJ, mipsCtrlPkg::opcJal, mipsCtrlPkg::opcAddi, mipsCtrlPkg::opcAddiu,
		mipsCtrlPkg::opcSlti, mipsCtrlPkg::opcSltiu, mipsCtrlPkg::opcAndi, mipsCtrlPkg::opcOri,
		mipsCtrlPkg::opcXori, mipsCtrlPkg::opcLui
	};

	logic [5:0] fnList[$] = '{
		mipsCtrlPkg::funAdd, mipsCtrlPkg::funSub, mipsCtrlPkg::funAddu, mipsCtrlPkg::funSubu,
		mipsCtrlPkg::funAnd, mipsCtrlPkg::funOr, mipsCtrlPkg::funXor, mipsCtrlPkg::funNor,
		mipsCtrlPkg::funSlt, mipsCtrlPkg::funSltu, mipsCtrlPkg::funSll, mipsCtrlPkg::funSrl,
		mipsCtrlPkg::funSra, mipsCtrlPkg::funSllv, mipsCtrlPkg::funSrlv, mipsCtrlPkg::funSrav,
		mipsCtrlPkg::funMfhi, mipsCtrlPkg::funMthi, mipsCtrlPkg::funMflo, mipsCtrlPkg::funMtlo,
		mipsCtrlPkg::funMult, mipsCtrlPkg::funMultu, mipsCtrlPkg::funDiv, mipsCtrlPkg::funDivu,
		mipsCtrlPkg::funJr, mipsCtrlPkg::funSyscall, mipsCtrlPkg::funMovz, mipsCtrlPkg::funMovn
	};

	controlUnit #(
		.numIrq (numIrq)
	) i_dut (
		.iCLK        (iCLK),
		.rstN        (rstN),
		.instr       (instr),
		.equal0      (equal0),
		.excLevel    (excLevel),
		.aluOverflow (aluOverflow),
		.userMode    (userMode),
		.pendingIrq  (pendingIrq),
		.ctrl        (ctrl),
		.exc         (exc)
	);

	initial
	begin
		forever
			#(period / 2) iCLK = ~iCLK;
	end

	function automatic mipsCtrlPkg::instr_t rWord(input logic [5:0] fn);
		return {mipsCtrlPkg::opcRType, 5'd4, 5'd5, 5'd6, 5'd0, fn};
	endfunction

	function automatic mipsCtrlPkg::instr_t iWord(input logic [5:0] op);
		return {op, 5'd1, 5'd2, 16'h1234};
	endfunction

	function automatic mipsCtrlPkg::instr_t copWord(input logic [4:0] fmt, input logic [5:0] fn);
		return {mipsCtrlPkg::opcCop0, fmt, 5'd8, 5'd12, 5'd0, fn};
	endfunction

	// expected outputs for one instruction and its status inputs
	function automatic void predict(input stim_t s, output mipsCtrlPkg::ctrlWord_t c,
		output mipsCtrlPkg::excOut_t e);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] fmt;
		logic irq;
		mipsCtrlPkg::excClass_t cls;
		op = s.w.rView.op;
		fn = s.w.rView.funct;
		fmt = s.w.copView.fmt;
		irq = |s.irq;
		c = '0;
		cls = mipsCtrlPkg::excIntOnly;
		if (op == mipsCtrlPkg::opcRType)
		begin
			if (fn == mipsCtrlPkg::funMovz || fn == mipsCtrlPkg::funMovn)
			begin
				c.regDst = 2'd1;
				c.memToReg = 3'd7;
				c.regWrite = (fn == mipsCtrlPkg::funMovz) ? s.eq0 : ~s.eq0;
				c.aluOp = (fn == mipsCtrlPkg::funMovn) ? 2'd1 : 2'd0;
				cls = mipsCtrlPkg::excAluOvf;
			end
			else if (fn == mipsCtrlPkg::funJr)
			begin
				c.pcSrc = 3'd3;
				c.branchDelay = 1'b1;
			end
			else if (fn == mipsCtrlPkg::funSyscall)
			begin
				c.pcSrc = 3'd4;
				cls = mipsCtrlPkg::excSyscall;
			end
			else if (fn inside {mipsCtrlPkg::funAdd, mipsCtrlPkg::funSub, mipsCtrlPkg::funAddu,
				mipsCtrlPkg::funSubu, mipsCtrlPkg::funAnd, mipsCtrlPkg::funOr,
				mipsCtrlPkg::funXor, mipsCtrlPkg::funNor, mipsCtrlPkg::funSlt,
				mipsCtrlPkg::funSltu, mipsCtrlPkg::funSll, mipsCtrlPkg::funSrl,
				mipsCtrlPkg::funSra, mipsCtrlPkg::funSllv, mipsCtrlPkg::funSrlv,
				mipsCtrlPkg::funSrav, mipsCtrlPkg::funMfhi, mipsCtrlPkg::funMthi,
				mipsCtrlPkg::funMflo, mipsCtrlPkg::funMtlo, mipsCtrlPkg::funMult,
				mipsCtrlPkg::funMultu, mipsCtrlPkg::funDiv, mipsCtrlPkg::funDivu})
			begin
				c.regDst = 2'd1;
				c.regWrite = 1'b1;
				c.aluOp = 2'd2;
				if (fn == mipsCtrlPkg::funAdd || fn == mipsCtrlPkg::funSub)
					cls = mipsCtrlPkg::excAluOvf;
			end
			else
				cls = mipsCtrlPkg::excReserved;
		end
		else if (op inside {mipsCtrlPkg::opcLw, mipsCtrlPkg::opcLh, mipsCtrlPkg::opcLb,
			mipsCtrlPkg::opcLhu, mipsCtrlPkg::opcLbu})
		begin
			c.aluSrc = 2'd1;
			c.memToReg = 3'd6;
			c.regWrite = 1'b1;
			c.memRead = 1'b1;
		end
		else if (op inside {mipsCtrlPkg::opcSw, mipsCtrlPkg::opcSh, mipsCtrlPkg::opcSb})
		begin
			c.aluSrc = 2'd1;
			c.memWrite = 1'b1;
		end
		else if (op == mipsCtrlPkg::opcBeq || op == mipsCtrlPkg::opcBne)
		begin
			c.pcSrc = (op == mipsCtrlPkg::opcBeq) ? 3'd1 : 3'd5;
			c.aluOp = 2'd1;
			c.branchDelay = 1'b1;
		end
		else if (op == mipsCtrlPkg::opcJ || op == mipsCtrlPkg::opcJal)
		begin
			c.regDst = (op == mipsCtrlPkg::opcJ) ? 2'd1 : 2'd2;
			c.memToReg = (op == mipsCtrlPkg::opcJ) ? 3'd0 : 3'd2;
			c.regWrite = (op == mipsCtrlPkg::opcJal);
			c.pcSrc = 3'd2;
			c.branchDelay = 1'b1;
		end
		else if (op inside {mipsCtrlPkg::opcAddi, mipsCtrlPkg::opcAddiu, mipsCtrlPkg::opcSlti,
			mipsCtrlPkg::opcSltiu, mipsCtrlPkg::opcAndi, mipsCtrlPkg::opcOri, mipsCtrlPkg::opcXori})
		begin
			// logical immediates are zero extended
			c.aluSrc = (op inside {mipsCtrlPkg::opcAndi, mipsCtrlPkg::opcOri,
				mipsCtrlPkg::opcXori}) ? 2'd2 : 2'd1;
			c.regWrite = 1'b1;
			c.aluOp = 2'd3;
			if (op == mipsCtrlPkg::opcAddi)
				cls = mipsCtrlPkg::excAluOvf;
		end
		else if (op == mipsCtrlPkg::opcLui)
		begin
			c.memToReg = 3'd3;
			c.regWrite = 1'b1;
		end
		else if (op == mipsCtrlPkg::opcCop0 && fmt == mipsCtrlPkg::fmtMf)
		begin
			c.memToReg = 3'd5;
			c.regWrite = 1'b1;
			cls = mipsCtrlPkg::excPrivileged;
		end
		else if (op == mipsCtrlPkg::opcCop0 && fmt == mipsCtrlPkg::fmtMt)
		begin
			c.cop0Write = 1'b1;
			cls = mipsCtrlPkg::excPrivileged;
		end
		else if (op == mipsCtrlPkg::opcCop0 && fmt == mipsCtrlPkg::fmtCo
			&& fn == mipsCtrlPkg::funEret)
		begin
			c.pcSrc = 3'd4;
			c.eret = 1'b1;
			cls = mipsCtrlPkg::excPrivileged;
		end
		else
			cls = mipsCtrlPkg::excReserved;

		e.code = mipsCtrlPkg::excCodeInt;
		case (cls)
			mipsCtrlPkg::excIntOnly:
				e.occurred = irq & ~s.excLvl;
			mipsCtrlPkg::excAluOvf:
			begin
				e.occurred = (s.ovf | irq) & ~s.excLvl;
				if (s.ovf)
					e.code = mipsCtrlPkg::excCodeAlu;
			end
			mipsCtrlPkg::excSyscall:
			begin
				e.occurred = ~s.excLvl;
				e.code = mipsCtrlPkg::excCodeSys;
			end
			mipsCtrlPkg::excReserved:
			begin
				e.occurred = ~s.excLvl;
				e.code = mipsCtrlPkg::excCodeInstr;
			end
			default:
			begin
				// privileged trap ignores excLevel
				e.occurred = s.user;
				e.code = mipsCtrlPkg::excCodeInstr;
				if (s.user)
				begin
					c.cop0Write = 1'b0;
					c.eret = 1'b0;
				end
			end
		endcase
	endfunction

	function automatic void addDir(input mipsCtrlPkg::instr_t w, input logic eq0,
		input logic excLvl, input logic ovf, input logic user, input logic [numIrq-1:0] irq);
		dirQ.push_back({w, eq0, excLvl, ovf, user, irq});
	endfunction

	function automatic void buildList();
		foreach (opList[i])
		begin
			if (i >= 2)
				addDir(iWord(opList[i]), 1'b0, 1'b0, 1'b0, 1'b0, '0);
		end
		foreach (fnList[i])
			addDir(rWord(fnList[i]), 1'b0, 1'b0, 1'b0, 1'b0, '0);
		addDir(rWord(mipsCtrlPkg::funMovz), 1'b1, 1'b0, 1'b0, 1'b0, '0);
		addDir(rWord(mipsCtrlPkg::funMovn), 1'b1, 1'b0, 1'b0, 1'b0, '0);
		// irq and overflow, then masked by excLevel
		addDir(rWord(mipsCtrlPkg::funAnd), 1'b0, 1'b0, 1'b0, 1'b0, 8'h04);
		addDir(rWord(mipsCtrlPkg::funAnd), 1'b0, 1'b1, 1'b0, 1'b0, 8'h04);
		addDir(rWord(mipsCtrlPkg::funAdd), 1'b0, 1'b0, 1'b1, 1'b0, '0);
		addDir(rWord(mipsCtrlPkg::funAdd), 1'b0, 1'b0, 1'b0, 1'b0, 8'h80);
		addDir(rWord(mipsCtrlPkg::funAdd), 1'b0, 1'b1, 1'b1, 1'b0, 8'h80);
		addDir(iWord(mipsCtrlPkg::opcAddi), 1'b0, 1'b0, 1'b1, 1'b0, '0);
		addDir(iWord(mipsCtrlPkg::opcAddiu), 1'b0, 1'b0, 1'b1, 1'b0, '0);
		addDir(rWord(mipsCtrlPkg::funSyscall), 1'b0, 1'b1, 1'b0, 1'b0, '0);
		addDir(iWord(6'h3f), 1'b0, 1'b0, 1'b0, 1'b0, '0);
		addDir(iWord(6'h3f), 1'b0, 1'b1, 1'b0, 1'b0, '0);
		addDir(rWord(6'h01), 1'b0, 1'b0, 1'b0, 1'b0, '0);
		addDir(rWord(6'h01), 1'b0, 1'b1, 1'b0, 1'b0, '0);
		addDir(copWord(5'd1, 6'h00), 1'b0, 1'b0, 1'b0, 1'b0, '0);
		addDir(copWord(mipsCtrlPkg::fmtCo, 6'h01), 1'b0, 1'b0, 1'b0, 1'b0, '0);
		// COP0 access in kernel then user mode
		for (int u = 0; u < 2; u++)
		begin
			addDir(copWord(mipsCtrlPkg::fmtMf, 6'h00), 1'b0, 1'b0, 1'b0, u[0], '0);
			addDir(copWord(mipsCtrlPkg::fmtMt, 6'h00), 1'b0, 1'b0, 1'b0, u[0], '0);
			addDir(copWord(mipsCtrlPkg::fmtCo, mipsCtrlPkg::funEret), 1'b0, 1'b1, 1'b0,
				u[0], 8'h01);
		end
	endfunction

	task automatic driveNow(input stim_t s);
		instr = s.w;
		equal0 = s.eq0;
		excLevel = s.excLvl;
		aluOverflow = s.ovf;
		userMode = s.user;
		pendingIrq = s.irq;
		predict(s, nextCtrl, nextExc);
	endtask

	task automatic applyStim(input stim_t s);
		@(posedge iCLK);
		#1;
		driveNow(s);
	endtask

	// expected outputs follow the DUT register by one edge
	always @(posedge iCLK)
	begin
		if (checkOn)
			checkCount <= checkCount + 2;
		checkOn <= 1'b1;
		if (!rstN)
		begin
			expCtrl <= '0;
			expExc <= '0;
		end
		else
		begin
			expCtrl <= nextCtrl;
			expExc <= nextExc;
		end
	end

	ctrlMatch: assert property (@(posedge iCLK) !checkOn || ctrl == expCtrl)
	else
	begin
		errCount++;
		$display("ERR ctrl got %h expected %h", $sampled(ctrl), $sampled(expCtrl));
	end

	excMatch: assert property (@(posedge iCLK) !checkOn || exc == expExc)
	else
	begin
		errCount++;
		$display("ERR exc got %h expected %h", $sampled(exc), $sampled(expExc));
	end

	initial
	begin
		wait (listReady);
		#((resetCycles + dirQ.size() + numRandom + 2 + 50) * period);
		$display("watchdog expired at %0t, the stimulus did not complete", $time);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		stim_t s;
		logic [31:0] r;
		int idx;
		rstN = 1'b0;
		buildList();
		listReady = 1'b1;
		// outputs stay clear despite busy inputs during reset
		driveNow({rWord(mipsCtrlPkg::funAdd), 1'b0, 1'b0, 1'b1, 1'b0, 8'hff});
		repeat (resetCycles) @(posedge iCLK);
		#1;
		rstN = 1'b1;

		foreach (dirQ[i])
			applyStim(dirQ[i]);

		repeat (numRandom)
		begin
			r = $random(seed);
			s.w = r;
			idx = $unsigned($random(seed)) % opList.size();
			s.w.rView.op = opList[idx];
			if (opList[idx] == mipsCtrlPkg::opcRType)
			begin
				idx = $unsigned($random(seed)) % fnList.size();
				s.w.rView.funct = fnList[idx];
			end
			else if (opList[idx] == mipsCtrlPkg::opcCop0)
			begin
				idx = $unsigned($random(seed)) % 3;
				if (idx == 0)
					s.w.copView.fmt = mipsCtrlPkg::fmtMf;
				else if (idx == 1)
					s.w.copView.fmt = mipsCtrlPkg::fmtMt;
				else
				begin
					s.w.copView.fmt = mipsCtrlPkg::fmtCo;
					s.w.copView.funct = mipsCtrlPkg::funEret;
				end
			end
			r = $random(seed);
			s.eq0 = r[0];
			s.excLvl = r[1];
			s.ovf = r[2];
			s.user = r[3];
			// irq pending about one time in four
			s.irq = (r[5:4] == 2'b00) ? r[8 +: numIrq] : '0;
			applyStim(s);
		end

		repeat (2) @(posedge iCLK);
		#1;
		$display("checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
	parameter int numIrq = 8
) (
	input  logic                   iCLK,
	input  logic                   rstN,
	input  mipsCtrlPkg::instr_t    instr,
	input  logic                   equal0,
	input  logic                   excLevel,
	input  logic                   aluOverflow,
	input  logic                   userMode,
	input  logic [numIrq-1:0]      pendingIrq,
	output mipsCtrlPkg::ctrlWord_t ctrl,
	output mipsCtrlPkg::excOut_t   exc
);

	mipsCtrlPkg::decodeOut_t decBus;

	// combinational decode
	opcodeDecoder uDecode (
		.instr  (instr),
		.equal0 (equal0),
		.dec    (decBus)
	);

	// exception resolution and output register
	commitStage #(
		.numIrq (numIrq)
	) uCommit (
		.iCLK        (iCLK),
		.rstN        (rstN),
		.dec         (decBus),
		.excLevel    (excLevel),
		.aluOverflow (aluOverflow),
		.userMode    (userMode),
		.pendingIrq  (pendingIrq),
		.ctrl        (ctrl),
		.exc         (exc)
	);

endmodule

//--- design/commitStage.sv
`timescale 1ns/1ps

module commitStage #(
	parameter int numIrq = 8
) (
	input  logic                    iCLK,
	input  logic                    rstN,
	input  mipsCtrlPkg::decodeOut_t dec,
	input  logic                    excLevel,
	input  logic                    aluOverflow,
	input  logic                    userMode,
	input  logic [numIrq-1:0]       pendingIrq,
	output mipsCtrlPkg::ctrlWord_t  ctrl,
	output mipsCtrlPkg::excOut_t    exc
);

	logic irq;
	mipsCtrlPkg::ctrlWord_t ctrlNext;
	mipsCtrlPkg::excOut_t excNext;

	assign irq = |pendingIrq;

	always_comb
	begin
		ctrlNext = dec.ctrl;
		case (dec.excClass)
			mipsCtrlPkg::excAluOvf:
			begin
				excNext.occurred = (aluOverflow | irq) & ~excLevel;
				excNext.code = aluOverflow ? mipsCtrlPkg::excCodeAlu : mipsCtrlPkg::excCodeInt;
			end
			mipsCtrlPkg::excSyscall:
			begin
				excNext.occurred = ~excLevel;
				excNext.code = mipsCtrlPkg::excCodeSys;
			end
			mipsCtrlPkg::excReserved:
			begin
				excNext.occurred = ~excLevel;
				excNext.code = mipsCtrlPkg::excCodeInstr;
			end
			mipsCtrlPkg::excPrivileged:
			begin
				// COP0 access from user mode traps and must not take effect
				excNext.occurred = userMode;
				excNext.code = mipsCtrlPkg::excCodeInstr;
				ctrlNext.cop0Write = dec.ctrl.cop0Write & ~userMode;
				ctrlNext.eret = dec.ctrl.eret & ~userMode;
			end
			default:
			begin
				// excIntOnly
				excNext.occurred = irq & ~excLevel;
				excNext.code = mipsCtrlPkg::excCodeInt;
			end
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			ctrl <= '0;
			exc <= '0;
		end
		else
		begin
			ctrl <= ctrlNext;
			exc <= excNext;
		end
	end

endmodule

//--- design/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder (
	input  mipsCtrlPkg::instr_t     instr,
	input  logic                    equal0,
	output mipsCtrlPkg::decodeOut_t dec
);

	mipsCtrlPkg::decodeOut_t rTypeDec;

	functDecoder uFunct (
		.instr  (instr),
		.equal0 (equal0),
		.dec    (rTypeDec)
	);

	always_comb
	begin
		dec.ctrl = '0;
		dec.excClass = mipsCtrlPkg::excIntOnly;
		case (instr.rView.op)
			mipsCtrlPkg::opcRType:
			begin
				dec = rTypeDec;
			end

			mipsCtrlPkg::opcSw,
			mipsCtrlPkg::opcSh,
			mipsCtrlPkg::opcSb:
			begin
				dec.ctrl.aluSrc = 2'd1;
				dec.ctrl.memWrite = 1'b1;
			end

			mipsCtrlPkg::opcLw,
			mipsCtrlPkg::opcLh,
			mipsCtrlPkg::opcLb,
			mipsCtrlPkg::opcLhu,
			mipsCtrlPkg::opcLbu:
			begin
				dec.ctrl.aluSrc = 2'd1;
				dec.ctrl.memToReg = 3'd6;
				dec.ctrl.regWrite = 1'b1;
				dec.ctrl.memRead = 1'b1;
			end

			mipsCtrlPkg::opcBeq,
			mipsCtrlPkg::opcBne:
			begin
				// BNE selects the inverted compare
				dec.ctrl.pcSrc = (instr.rView.op == mipsCtrlPkg::opcBne) ? 3'd5 : 3'd1;
				dec.ctrl.aluOp = 2'd1;
				dec.ctrl.branchDelay = 1'b1;
			end

			mipsCtrlPkg::opcJ:
			begin
				dec.ctrl.regDst = 2'd1;
				dec.ctrl.pcSrc = 3'd2;
				dec.ctrl.branchDelay = 1'b1;
			end

			mipsCtrlPkg::opcJal:
			begin
				// link into $ra
				dec.ctrl.regDst = 2'd2;
				dec.ctrl.memToReg = 3'd2;
				dec.ctrl.regWrite = 1'b1;
				dec.ctrl.pcSrc = 3'd2;
				dec.ctrl.branchDelay = 1'b1;
			end

			mipsCtrlPkg::opcAddi,
			mipsCtrlPkg::opcAddiu,
			mipsCtrlPkg::opcSlti,
			mipsCtrlPkg::opcSltiu:
			begin
				dec.ctrl.aluSrc = 2'd1;
				dec.ctrl.regWrite = 1'b1;
				dec.ctrl.aluOp = 2'd3;
				if (instr.rView.op == mipsCtrlPkg::opcAddi)
					dec.excClass = mipsCtrlPkg::excAluOvf;
			end

			mipsCtrlPkg::opcAndi,
			mipsCtrlPkg::opcOri,
			mipsCtrlPkg::opcXori:
			begin
				// zero-extended immediate
				dec.ctrl.aluSrc = 2'd2;
				dec.ctrl.regWrite = 1'b1;
				dec.ctrl.aluOp = 2'd3;
			end

			mipsCtrlPkg::opcLui:
			begin
				dec.ctrl.memToReg = 3'd3;
				dec.ctrl.regWrite = 1'b1;
			end

			mipsCtrlPkg::opcCop0:
			begin
				dec.excClass = mipsCtrlPkg::excPrivileged;
				case (instr.copView.fmt)
					mipsCtrlPkg::fmtMf:
					begin
						dec.ctrl.memToReg = 3'd5;
						dec.ctrl.regWrite = 1'b1;
					end
					mipsCtrlPkg::fmtMt:
						dec.ctrl.cop0Write = 1'b1;
					mipsCtrlPkg::fmtCo:
					begin
						if (instr.copView.funct == mipsCtrlPkg::funEret)
						begin
							dec.ctrl.pcSrc = 3'd4;
							dec.ctrl.eret = 1'b1;
						end
						else
							dec.excClass = mipsCtrlPkg::excReserved;
					end
					default:
						dec.excClass = mipsCtrlPkg::excReserved;
				endcase
			end

			default:
				dec.excClass = mipsCtrlPkg::excReserved;
		endcase
	end

endmodule

//--- design/functDecoder.sv
`timescale 1ns/1ps

module functDecoder (
	input  mipsCtrlPkg::instr_t     instr,
	input  logic                    equal0,
	output mipsCtrlPkg::decodeOut_t dec
);

	always_comb
	begin
		dec.ctrl = '0;
		dec.excClass = mipsCtrlPkg::excIntOnly;
		case (instr.rView.funct)
			mipsCtrlPkg::funAdd,
			mipsCtrlPkg::funSub,
			mipsCtrlPkg::funAddu,
			mipsCtrlPkg::funSubu,
			mipsCtrlPkg::funAnd,
			mipsCtrlPkg::funOr,
			mipsCtrlPkg::funXor,
			mipsCtrlPkg::funNor,
			mipsCtrlPkg::funSlt,
			mipsCtrlPkg::funSltu,
			mipsCtrlPkg::funSll,
			mipsCtrlPkg::funSrl,
			mipsCtrlPkg::funSra,
			mipsCtrlPkg::funSllv,
			mipsCtrlPkg::funSrlv,
			mipsCtrlPkg::funSrav,
			mipsCtrlPkg::funMfhi,
			mipsCtrlPkg::funMthi,
			mipsCtrlPkg::funMflo,
			mipsCtrlPkg::funMtlo,
			mipsCtrlPkg::funMult,
			mipsCtrlPkg::funMultu,
			mipsCtrlPkg::funDiv,
			mipsCtrlPkg::funDivu:
			begin
				dec.ctrl.regDst = 2'd1;
				dec.ctrl.regWrite = 1'b1;
				dec.ctrl.aluOp = 2'd2;
				// only the signed add and sub trap
				if (instr.rView.funct == mipsCtrlPkg::funAdd ||
					instr.rView.funct == mipsCtrlPkg::funSub)
					dec.excClass = mipsCtrlPkg::excAluOvf;
			end

			mipsCtrlPkg::funMovz,
			mipsCtrlPkg::funMovn:
			begin
				dec.ctrl.regDst = 2'd1;
				dec.ctrl.memToReg = 3'd7;
				dec.excClass = mipsCtrlPkg::excAluOvf;
				if (instr.rView.funct == mipsCtrlPkg::funMovn)
				begin
					dec.ctrl.regWrite = ~equal0;
					dec.ctrl.aluOp = 2'd1;
				end
				else
					dec.ctrl.regWrite = equal0;
			end

			mipsCtrlPkg::funJr:
			begin
				dec.ctrl.pcSrc = 3'd3;
				dec.ctrl.branchDelay = 1'b1;
			end

			mipsCtrlPkg::funSyscall:
			begin
				dec.ctrl.pcSrc = 3'd4;
				dec.excClass = mipsCtrlPkg::excSyscall;
			end

			default:
				dec.excClass = mipsCtrlPkg::excReserved;
		endcase
	end

endmodule

//--- design/mipsCtrlPkg.sv
package mipsCtrlPkg;

	// primary opcodes
	localparam logic [5:0] opcRType = 6'h00;
	localparam logic [5:0] opcJ     = 6'h02;
	localparam logic [5:0] opcJal   = 6'h03;
	localparam logic [5:0] opcBeq   = 6'h04;
	localparam logic [5:0] opcBne   = 6'h05;
	localparam logic [5:0] opcAddi  = 6'h08;
	localparam logic [5:0] opcAddiu = 6'h09;
	localparam logic [5:0] opcSlti  = 6'h0a;
	localparam logic [5:0] opcSltiu = 6'h0b;
	localparam logic [5:0] opcAndi  = 6'h0c;
	localparam logic [5:0] opcOri   = 6'h0d;
	localparam logic [5:0] opcXori  = 6'h0e;
	localparam logic [5:0] opcLui   = 6'h0f;
	localparam logic [5:0] opcCop0  = 6'h10;
	localparam logic [5:0] opcLb    = 6'h20;
	localparam logic [5:0] opcLh    = 6'h21;
	localparam logic [5:0] opcLw    = 6'h23;
	localparam logic [5:0] opcLbu   = 6'h24;
	localparam logic [5:0] opcLhu   = 6'h25;
	localparam logic [5:0] opcSb    = 6'h28;
	localparam logic [5:0] opcSh    = 6'h29;
	localparam logic [5:0] opcSw    = 6'h2b;

	// R-type funct codes
	localparam logic [5:0] funSll     = 6'h00;
	localparam logic [5:0] funSrl     = 6'h02;
	localparam logic [5:0] funSra     = 6'h03;
	localparam logic [5:0] funSllv    = 6'h04;
	localparam logic [5:0] funSrlv    = 6'h06;
	localparam logic [5:0] funSrav    = 6'h07;
	localparam logic [5:0] funJr      = 6'h08;
	localparam logic [5:0] funMovz    = 6'h0a;
	localparam logic [5:0] funMovn    = 6'h0b;
	localparam logic [5:0] funSyscall = 6'h0c;
	localparam logic [5:0] funMfhi    = 6'h10;
	localparam logic [5:0] funMthi    = 6'h11;
	localparam logic [5:0] funMflo    = 6'h12;
	localparam logic [5:0] funMtlo    = 6'h13;
	localparam logic [5:0] funMult    = 6'h18;
	localparam logic [5:0] funMultu   = 6'h19;
	localparam logic [5:0] funDiv     = 6'h1a;
	localparam logic [5:0] funDivu    = 6'h1b;
	localparam logic [5:0] funAdd     = 6'h20;
	localparam logic [5:0] funAddu    = 6'h21;
	localparam logic [5:0] funSub     = 6'h22;
	localparam logic [5:0] funSubu    = 6'h23;
	localparam logic [5:0] funAnd     = 6'h24;
	localparam logic [5:0] funOr      = 6'h25;
	localparam logic [5:0] funXor     = 6'h26;
	localparam logic [5:0] funNor     = 6'h27;
	localparam logic [5:0] funSlt     = 6'h2a;
	localparam logic [5:0] funSltu    = 6'h2b;
	// ERET funct under the COP0 CO format
	localparam logic [5:0] funEret    = 6'h18;

	// COP0 formats, in the rs slot
	localparam logic [4:0] fmtMf = 5'd0;
	localparam logic [4:0] fmtMt = 5'd4;
	localparam logic [4:0] fmtCo = 5'd16;

	// cause register exception codes
	localparam logic [4:0] excCodeInt   = 5'd0;
	localparam logic [4:0] excCodeSys   = 5'd8;
	localparam logic [4:0] excCodeInstr = 5'd10;
	localparam logic [4:0] excCodeAlu   = 5'd12;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] fmt;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] unused;
		logic [5:0] funct;
	} copFields_t;

	// same word seen as R-type or as COP0
	typedef union packed {
		rFields_t   rView;
		copFields_t copView;
	} instr_t;

	typedef enum logic [2:0] {
		excIntOnly,
		excAluOvf,
		excSyscall,
		excReserved,
		excPrivileged
	} excClass_t;

	typedef struct packed {
		logic [1:0] regDst;
		logic [1:0] aluSrc;
		logic [2:0] memToReg;
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
		logic [2:0] pcSrc;
		logic [1:0] aluOp;
		logic       cop0Write;
		logic       eret;
		logic       branchDelay;
	} ctrlWord_t;

	typedef struct packed {
		logic       occurred;
		logic [4:0] code;
	} excOut_t;

	typedef struct packed {
		ctrlWord_t ctrl;
		excClass_t excClass;
	} decodeOut_t;

endpackage
